// File: all.f
design/mem_types_pkg.sv
design/axi_pkg.sv
design/dual_write_fifo.sv
design/victim_line_buf.sv
design/mem_write.sv
design/axi_wr_ram.sv
design/mem_write_top.sv
dv/mem_write_tb.sv

// File: Makefile
# Verilator build and run for the memory-stage write path
VERILATOR ?= verilator
TOP       ?= mem_write_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/mem_write_tb.sv
`default_nettype none

module mem_write_tb;

    localparam int FIFO_DEPTH    = 16;
    localparam int LINE_WORD_NUM = 8;
    localparam int RAM_WORDS     = 256;
    localparam int BUFFER_NUM    = FIFO_DEPTH / 2;
    localparam int TEST_NUM      = 5;
    localparam int LIMIT_CYCLES  = 2000 * TEST_NUM; // 2000 cycles per test

    typedef mem_types_pkg::word [LINE_WORD_NUM-1:0] line_t;

    logic                          i_clk;
    logic                          i_rst;
    logic                          i_dcache_we;
    mem_types_pkg::word            i_dcache_addr;
    line_t                         i_dcache_line;
    logic                          i_sram_we;
    mem_types_pkg::word            i_sram_addr;
    mem_types_pkg::word            i_sram_data;
    logic [3:0]                    i_sram_wen;
    logic                          i_bus_stall;
    mem_types_pkg::word            i_rd_addr;
    logic [$clog2(FIFO_DEPTH)-2:0] o_dcache_lock;
    logic                          o_dcache_full;
    logic                          o_sram_full;
    logic                          o_empty;
    logic                          o_dcache_end;
    logic                          o_sram_end;
    mem_types_pkg::word            o_rd_data;

    mem_types_pkg::word shadow [RAM_WORDS]; // expected ram contents
    bit                 touched [RAM_WORDS];
    mem_types_pkg::word pend_addr [$];      // stores held back while stalled
    mem_types_pkg::word pend_data [$];
    logic [3:0]         pend_wen [$];
    integer             seed;
    int                 err_cnt;
    int                 check_cnt;
    int                 test_cnt;
    int                 sram_sent;
    int                 line_sent;
    int                 sram_ends;
    int                 line_ends;
    bit                 cmp_go;

    mem_write_top #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .LINE_WORD_NUM(LINE_WORD_NUM),
        .RAM_WORDS    (RAM_WORDS)
    ) mem_write_top_inst (.*);

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    // byte strobe rule of an axi write beat
    function automatic mem_types_pkg::word merge_bytes(input mem_types_pkg::word old_w,
                                                       input mem_types_pkg::word new_w,
                                                       input logic [3:0] strb);
        mem_types_pkg::word res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < LINE_WORD_NUM; k++) begin
            l[k] = $random(seed);
        end
        return l;
    endfunction

    task automatic ref_store(input mem_types_pkg::word addr, input mem_types_pkg::word data,
                             input logic [3:0] wen);
        int idx;
        idx = int'(addr[31:2]) % RAM_WORDS;
        shadow[idx]  = merge_bytes(shadow[idx], data, wen);
        touched[idx] = 1'b1;
    endtask

    task automatic ref_line(input mem_types_pkg::word addr, input line_t l);
        int idx;
        for (int k = 0; k < LINE_WORD_NUM; k++) begin
            idx = (int'(addr[31:2]) + k) % RAM_WORDS;
            shadow[idx]  = l[k];
            touched[idx] = 1'b1;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // one cycle of requests, called on a falling edge
    task automatic issue(input bit do_s, input mem_types_pkg::word s_addr,
                         input mem_types_pkg::word s_data, input logic [3:0] s_wen,
                         input bit do_l, input mem_types_pkg::word l_addr,
                         input line_t l_data, input bit defer);
        i_sram_we     = do_s;
        i_sram_addr   = s_addr;
        i_sram_data   = s_data;
        i_sram_wen    = s_wen;
        i_dcache_we   = do_l;
        i_dcache_addr = l_addr;
        i_dcache_line = l_data;
        if (do_s) begin // uncached goes first on a tie
            sram_sent++;
            if (defer) begin
                pend_addr.push_back(s_addr);
                pend_data.push_back(s_data);
                pend_wen.push_back(s_wen);
            end else begin
                ref_store(s_addr, s_data, s_wen);
            end
        end
        if (do_l) begin
            line_sent++;
            ref_line(l_addr, l_data);
        end
        @(negedge i_clk);
        i_sram_we   = 1'b0;
        i_dcache_we = 1'b0;
    endtask

    task automatic wait_idle();
        while (!o_empty) begin
            @(negedge i_clk);
        end
        check_value("o_sram_end count", 32'(sram_ends), 32'(sram_sent));
        check_value("o_dcache_end count", 32'(line_ends), 32'(line_sent));
    endtask

    task automatic run_compare();
        cmp_go = 1'b1;
        wait (!cmp_go);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (o_sram_end) begin
                sram_ends++;
            end
            if (o_dcache_end) begin
                line_ends++;
            end
        end
    end

    // reads back every touched word and checks it against the shadow
    initial begin : compare_ram
        i_rd_addr = '0;
        forever begin
            wait (cmp_go);
            for (int i = 0; i < RAM_WORDS; i++) begin
                if (touched[i]) begin
                    i_rd_addr = 32'(i * 4);
                    @(negedge i_clk);
                    check_value($sformatf("o_rd_data at 0x%h", i * 4), o_rd_data, shadow[i]);
                end
            end
            cmp_go = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge i_clk);
        $display("timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        int                 errs;
        logic [31:0]        r;
        bit                 do_s;
        bit                 do_l;
        mem_types_pkg::word a;
        mem_types_pkg::word d;
        seed          = 32'h2ae7;
        i_rst         = 1'b1;
        i_dcache_we   = 1'b0;
        i_dcache_addr = '0;
        i_dcache_line = '0;
        i_sram_we     = 1'b0;
        i_sram_addr   = '0;
        i_sram_data   = '0;
        i_sram_wen    = '0;
        i_bus_stall   = 1'b0;
        repeat (2) @(negedge i_clk);
        i_rst = 1'b0;

        errs = err_cnt;
        check_value("o_empty", 32'(o_empty), 32'h1);
        check_value("o_sram_full", 32'(o_sram_full), 32'h0);
        check_value("o_dcache_full", 32'(o_dcache_full), 32'h0);
        issue(1'b1, 32'h40, 32'h1122_3344, 4'hf, 1'b0, '0, '0, 1'b0);
        wait_idle();
        issue(1'b1, 32'h40, 32'haabb_ccdd, 4'b0101, 1'b0, '0, '0, 1'b0);
        wait_idle();
        run_compare();
        report_test("uncached partial strobe", errs);

        errs = err_cnt;
        issue(1'b0, '0, '0, '0, 1'b1, 32'h80, random_line(), 1'b0);
        wait_idle();
        run_compare();
        report_test("line eviction", errs);

        errs = err_cnt;
        for (int n = 0; n < 40; n++) begin
            r    = $random(seed);
            d    = $random(seed);
            do_s = r[0] && !o_sram_full;
            do_l = r[1] && !o_dcache_full;
            a    = {24'h0, r[13:8], 2'b00};
            if (do_s || do_l) begin
                // line is aligned around the store so a tie overlaps
                issue(do_s, a, d, r[19:16], do_l, a & ~32'(LINE_WORD_NUM * 4 - 1),
                      random_line(), 1'b0);
            end else begin
                @(negedge i_clk);
            end
        end
        wait_idle();
        run_compare();
        report_test("random mix", errs);

        errs = err_cnt;
        i_bus_stall = 1'b1;
        for (int k = 0; k < BUFFER_NUM - 1; k++) begin
            check_value("o_sram_full", 32'(o_sram_full), 32'h0);
            d = $random(seed);
            r = $random(seed);
            issue(1'b1, 32'(32'h80 + 4 * (k % LINE_WORD_NUM)), d, r[3:0], 1'b0, '0, '0, 1'b1);
        end
        check_value("o_sram_full", 32'(o_sram_full), 32'h1);
        repeat (20) @(negedge i_clk);
        check_value("o_empty", 32'(o_empty), 32'h0);
        run_compare(); // nothing may land while stalled
        while (pend_addr.size() > 0) begin
            ref_store(pend_addr.pop_front(), pend_data.pop_front(), pend_wen.pop_front());
        end
        i_bus_stall = 1'b0;
        wait_idle();
        check_value("o_sram_full", 32'(o_sram_full), 32'h0);
        run_compare();
        report_test("uncached back-pressure", errs);

        errs = err_cnt;
        i_bus_stall = 1'b1;
        for (int k = 0; k < BUFFER_NUM; k++) begin
            check_value("o_dcache_full", 32'(o_dcache_full), 32'h0);
            check_value("o_dcache_lock", 32'(o_dcache_lock), 32'(k));
            issue(1'b0, '0, '0, '0, 1'b1, 32'(32'h200 + k * LINE_WORD_NUM * 4),
                  random_line(), 1'b0);
        end
        check_value("o_dcache_full", 32'(o_dcache_full), 32'h1);
        i_bus_stall = 1'b0;
        while (!o_dcache_end) begin
            @(negedge i_clk);
        end
        @(negedge i_clk);
        check_value("o_dcache_full", 32'(o_dcache_full), 32'h0);
        check_value("o_dcache_lock", 32'(o_dcache_lock), 32'h0);
        issue(1'b0, '0, '0, '0, 1'b1, 32'h200, random_line(), 1'b0); // reuses slot 0
        wait_idle();
        run_compare();
        report_test("slot grant and reuse", errs);

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/mem_write_top.sv
`default_nettype none

module mem_write_top #(
    parameter int FIFO_DEPTH    = 16,
    parameter int LINE_WORD_NUM = 8,
    parameter int RAM_WORDS     = 256
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst,
    input  logic                                   i_dcache_we,
    input  mem_types_pkg::word                     i_dcache_addr,
    input  mem_types_pkg::word [LINE_WORD_NUM-1:0] i_dcache_line,
    input  logic                                   i_sram_we,
    input  mem_types_pkg::word                     i_sram_addr,
    input  mem_types_pkg::word                     i_sram_data,
    input  logic [3:0]                             i_sram_wen,
    input  logic                                   i_bus_stall,
    input  mem_types_pkg::word                     i_rd_addr,
    output logic [$clog2(FIFO_DEPTH)-2:0]          o_dcache_lock,
    output logic                                   o_dcache_full,
    output logic                                   o_sram_full,
    output logic                                   o_empty,
    output logic                                   o_dcache_end,
    output logic                                   o_sram_end,
    output mem_types_pkg::word                     o_rd_data
);

    mem_types_pkg::mem_write_req            w_dcache_req;
    mem_types_pkg::mem_write_req            w_sram_req;
    mem_types_pkg::word [LINE_WORD_NUM-1:0] w_head_line;
    logic [$clog2(FIFO_DEPTH)-1:0]          w_key;
    logic [$clog2(FIFO_DEPTH)-2:0]          w_dcache_lock;
    axi_pkg::axi_w_req                      w_axi_req;
    axi_pkg::axi_w_resp                     w_axi_resp;

    // full line burst of words
    assign w_dcache_req.addr = i_dcache_addr;
    assign w_dcache_req.len  = 8'(LINE_WORD_NUM - 1);
    assign w_dcache_req.size = 3'd2;
    assign w_dcache_req.wen  = 4'hf;

    // single beat, caller strobe
    assign w_sram_req.addr = i_sram_addr;
    assign w_sram_req.len  = 8'd0;
    assign w_sram_req.size = 3'd2;
    assign w_sram_req.wen  = i_sram_wen;

    assign o_dcache_lock = w_dcache_lock;

    victim_line_buf #(
        .LINE_WORD_NUM(LINE_WORD_NUM),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) victim_line_buf_inst (
        .i_clk    (i_clk),
        .i_we     (i_dcache_we),
        .i_slot   (w_dcache_lock),
        .i_line   (i_dcache_line),
        .i_rd_slot(w_key[$clog2(FIFO_DEPTH)-2:0]),
        .o_line   (w_head_line)
    );

    mem_write #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .LINE_WORD_NUM(LINE_WORD_NUM)
    ) mem_write_inst (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_dcache_we   (i_dcache_we),
        .i_sram_we     (i_sram_we),
        .i_dcache_data (w_head_line),
        .i_sram_data   (i_sram_data),
        .i_dcache_req  (w_dcache_req),
        .i_sram_req    (w_sram_req),
        .axi_bus_resp  (w_axi_resp),
        .o_dcache_lock (w_dcache_lock),
        .o_dcache_full (o_dcache_full),
        .o_sram_full   (o_sram_full),
        .o_key         (w_key),
        .o_empty       (o_empty),
        .o_dcache_start(),
        .o_dcache_end  (o_dcache_end),
        .o_sram_start  (),
        .o_sram_end    (o_sram_end),
        .axi_bus_req   (w_axi_req)
    );

    axi_wr_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) axi_wr_ram_inst (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_stall   (i_bus_stall),
        .i_axi_req (w_axi_req),
        .i_rd_addr (i_rd_addr),
        .o_axi_resp(w_axi_resp),
        .o_rd_data (o_rd_data)
    );

endmodule

`default_nettype wire

// File: design/axi_wr_ram.sv
`default_nettype none

module axi_wr_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_stall,
    input  axi_pkg::axi_w_req  i_axi_req,
    input  mem_types_pkg::word i_rd_addr,
    output axi_pkg::axi_w_resp o_axi_resp,
    output mem_types_pkg::word o_rd_data
);

    localparam int ADDR_W = $clog2(RAM_WORDS);

    mem_types_pkg::word mem [RAM_WORDS];
    logic [ADDR_W-1:0]  r_waddr; // word address of next beat
    logic               r_incr;
    logic               r_awready;
    logic               r_wready;
    logic               r_bvalid;
    logic               r_busy;
    logic               w_aw_fire;
    logic               w_w_fire;

    assign w_aw_fire = i_axi_req.awvalid && r_awready;
    assign w_w_fire  = i_axi_req.wvalid && r_wready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_awready <= 1'b0;
            r_wready  <= 1'b0;
            r_bvalid  <= 1'b0;
            r_busy    <= 1'b0;
        end else begin
            r_awready <= i_axi_req.awvalid && !r_awready && !r_busy && !i_stall;
            r_bvalid  <= w_w_fire && i_axi_req.wlast; // one cycle after last beat
            if (w_aw_fire) begin
                r_busy   <= 1'b1;
                r_wready <= 1'b1;
            end else if (w_w_fire && i_axi_req.wlast) begin
                r_wready <= 1'b0;
            end
            if (r_bvalid) begin
                r_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_aw_fire) begin
            r_waddr <= i_axi_req.awaddr[ADDR_W+1:2];
            r_incr  <= (i_axi_req.awburst == axi_pkg::BURST_INCR);
        end else if (w_w_fire && r_incr) begin
            r_waddr <= r_waddr + 1'b1;
        end
        if (w_w_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (i_axi_req.wstrb[b]) begin
                    mem[r_waddr][8*b +: 8] <= i_axi_req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign o_axi_resp.awready = r_awready;
    assign o_axi_resp.wready  = r_wready;
    assign o_axi_resp.bvalid  = r_bvalid;
    assign o_axi_resp.bresp   = 2'b00; // always okay
    assign o_rd_data = mem[i_rd_addr[ADDR_W+1:2]];

endmodule

`default_nettype wire

// File: design/mem_write.sv
`default_nettype none

module mem_write #(
    parameter int FIFO_DEPTH    = 16,
    parameter int LINE_WORD_NUM = 8
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst,
    input  logic                                   i_dcache_we,
    input  logic                                   i_sram_we,
    input  mem_types_pkg::word [LINE_WORD_NUM-1:0] i_dcache_data,
    input  mem_types_pkg::word                     i_sram_data,
    input  mem_types_pkg::mem_write_req            i_dcache_req,
    input  mem_types_pkg::mem_write_req            i_sram_req,
    input  axi_pkg::axi_w_resp                     axi_bus_resp,
    output logic [$clog2(FIFO_DEPTH)-2:0]          o_dcache_lock,
    output logic                                   o_dcache_full,
    output logic                                   o_sram_full,
    output logic [$clog2(FIFO_DEPTH)-1:0]          o_key,
    output logic                                   o_empty,
    output logic                                   o_dcache_start,
    output logic                                   o_dcache_end,
    output logic                                   o_sram_start,
    output logic                                   o_sram_end,
    output axi_pkg::axi_w_req                      axi_bus_req
);

    localparam int BUFFER_NUM = FIFO_DEPTH / 2;
    localparam int KEY_W      = $clog2(FIFO_DEPTH);
    localparam int SLOT_W     = KEY_W - 1;
    localparam int CNT_W      = $clog2(LINE_WORD_NUM);
    localparam int ENTRY_W    = KEY_W + $bits(mem_types_pkg::mem_write_req)
                                + $bits(mem_types_pkg::word);

    // lowest clear bit of a slot history
    function automatic logic [SLOT_W-1:0] first_free(input logic [BUFFER_NUM-1:0] hist);
        logic [SLOT_W-1:0] idx;
        idx = '0;
        for (int i = BUFFER_NUM - 1; i >= 0; i--) begin
            if (!hist[i]) begin
                idx = SLOT_W'(i);
            end
        end
        return idx;
    endfunction

    logic [1:0][BUFFER_NUM-1:0]             r_history; // [1] uncached, [0] cache lines
    logic [SLOT_W-1:0]                      w_dcache_lock;
    logic [SLOT_W-1:0]                      w_sram_lock;
    logic [ENTRY_W-1:0]                     w_head;
    logic [KEY_W-1:0]                       w_key;
    mem_types_pkg::mem_write_req            w_head_req;
    mem_types_pkg::word                     w_head_data;
    logic                                   w_empty_a;
    logic                                   w_empty_b;
    logic                                   w_empty;
    logic                                   w_is_sram;
    mem_types_pkg::word [LINE_WORD_NUM-1:0] r_data;
    logic [7:0]                             r_cnt;
    logic                                   r_awvalid;
    logic                                   r_wvalid;
    logic                                   r_busy;
    logic                                   w_aw_fire;
    logic                                   w_w_fire;
    logic                                   w_last;
    logic                                   w_pop;

    assign w_dcache_lock = first_free(r_history[0]);
    assign w_sram_lock   = first_free(r_history[1]);
    assign o_dcache_lock = w_dcache_lock;
    assign o_dcache_full = &r_history[0];
    assign o_sram_full   = $countones(r_history[1]) >= BUFFER_NUM - 1;

    dual_write_fifo #(
        .DATA_WIDTH (ENTRY_W),
        .DEPTH      (FIFO_DEPTH)
    ) fifo_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_push_a (i_sram_we), // uncached goes ahead on a tie
        .i_data_a ({1'b1, w_sram_lock, i_sram_req, i_sram_data}),
        .i_push_b (i_dcache_we),
        .i_data_b ({1'b0, w_dcache_lock, i_dcache_req, 32'h0}),
        .i_pop    (w_pop),
        .o_data   (w_head),
        .o_empty_a(w_empty_a),
        .o_empty_b(w_empty_b)
    );

    assign {w_key, w_head_req, w_head_data} = w_head;
    assign w_empty   = w_empty_a && w_empty_b;
    assign w_is_sram = w_key[KEY_W-1];
    assign o_key     = w_key;
    assign o_empty   = w_empty;

    assign w_aw_fire = r_awvalid && axi_bus_resp.awready;
    assign w_w_fire  = r_wvalid && axi_bus_resp.wready;
    assign w_last    = (r_cnt == w_head_req.len);
    assign w_pop     = r_busy && axi_bus_resp.bvalid; // request done at b

    assign o_sram_start   = w_aw_fire && w_is_sram;
    assign o_dcache_start = w_aw_fire && !w_is_sram;
    assign o_sram_end     = w_pop && w_is_sram;
    assign o_dcache_end   = w_pop && !w_is_sram;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_history <= '0;
            r_awvalid <= 1'b0;
            r_wvalid  <= 1'b0;
            r_busy    <= 1'b0;
            r_cnt     <= '0;
        end else begin
            if (w_pop) begin
                r_history[w_key[KEY_W-1]][w_key[SLOT_W-1:0]] <= 1'b0;
            end
            if (i_dcache_we) begin
                r_history[0][w_dcache_lock] <= 1'b1;
            end
            if (i_sram_we) begin
                r_history[1][w_sram_lock] <= 1'b1;
            end
            if (!r_busy && !w_empty) begin
                r_awvalid <= 1'b1;
                r_busy    <= 1'b1;
            end else if (w_aw_fire) begin
                r_awvalid <= 1'b0;
            end
            if (w_pop) begin
                r_busy <= 1'b0;
            end
            if (w_aw_fire) begin
                r_wvalid <= 1'b1;
                r_cnt    <= '0;
            end else if (w_w_fire) begin
                r_cnt <= r_cnt + 1'b1;
                if (w_last) begin
                    r_wvalid <= 1'b0;
                end
            end
        end
    end

    // burst payload captured when aw is taken
    always_ff @(posedge i_clk) begin
        if (w_aw_fire) begin
            if (w_is_sram) begin
                r_data[0] <= w_head_data;
            end else begin
                r_data <= i_dcache_data;
            end
        end
    end

    assign axi_bus_req.awid    = 4'h0;
    assign axi_bus_req.awaddr  = w_head_req.addr;
    assign axi_bus_req.awlen   = w_head_req.len;
    assign axi_bus_req.awsize  = w_head_req.size;
    assign axi_bus_req.awburst = (w_head_req.len == '0) ? axi_pkg::BURST_FIXED
                                                        : axi_pkg::BURST_INCR;
    assign axi_bus_req.awlock  = 2'b00;
    assign axi_bus_req.awcache = 4'h0;
    assign axi_bus_req.awprot  = 3'b000;
    assign axi_bus_req.awvalid = r_awvalid;
    assign axi_bus_req.wid     = 4'h0;
    assign axi_bus_req.wdata   = r_data[r_cnt[CNT_W-1:0]];
    assign axi_bus_req.wstrb   = w_head_req.wen;
    assign axi_bus_req.wlast   = r_wvalid && w_last;
    assign axi_bus_req.wvalid  = r_wvalid;
    assign axi_bus_req.bready  = 1'b1;

endmodule

`default_nettype wire

// File: design/victim_line_buf.sv
`default_nettype none

module victim_line_buf #(
    parameter int LINE_WORD_NUM = 8,
    parameter int FIFO_DEPTH    = 16
) (
    input  logic                                        i_clk,
    input  logic                                        i_we,
    input  logic [$clog2(FIFO_DEPTH)-2:0]               i_slot,
    input  mem_types_pkg::word [LINE_WORD_NUM-1:0]      i_line,
    input  logic [$clog2(FIFO_DEPTH)-2:0]               i_rd_slot,
    output mem_types_pkg::word [LINE_WORD_NUM-1:0]      o_line
);

    localparam int BUFFER_NUM = FIFO_DEPTH / 2;

    // one evicted line per cache slot
    mem_types_pkg::word [LINE_WORD_NUM-1:0] lines [BUFFER_NUM];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            lines[i_slot] <= i_line; // slot granted by mem_write
        end
    end

    // head of queue reads its line without delay
    assign o_line = lines[i_rd_slot];

endmodule

`default_nettype wire

// File: design/dual_write_fifo.sv
`default_nettype none

module dual_write_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 16
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_push_a,
    input  logic [DATA_WIDTH-1:0] i_data_a,
    input  logic                  i_push_b,
    input  logic [DATA_WIDTH-1:0] i_data_b,
    input  logic                  i_pop,
    output logic [DATA_WIDTH-1:0] o_data,
    output logic                  o_empty_a,
    output logic                  o_empty_b
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [DEPTH-1:0]      src_b; // entry came in on port b
    logic [PTR_W-1:0]      r_wr_ptr;
    logic [PTR_W-1:0]      r_rd_ptr;
    logic [PTR_W-1:0]      w_wr_ptr_b;
    logic [CNT_W-1:0]      r_cnt_a;
    logic [CNT_W-1:0]      r_cnt_b;
    logic                  w_pop_a;
    logic                  w_pop_b;

    assign w_wr_ptr_b = i_push_a ? r_wr_ptr + 1'b1 : r_wr_ptr; // b lands behind a
    assign w_pop_a    = i_pop && !src_b[r_rd_ptr];
    assign w_pop_b    = i_pop && src_b[r_rd_ptr];

    assign o_data    = mem[r_rd_ptr];
    assign o_empty_a = (r_cnt_a == '0);
    assign o_empty_b = (r_cnt_b == '0);

    always_ff @(posedge i_clk) begin
        if (i_push_a) begin
            mem[r_wr_ptr]   <= i_data_a;
            src_b[r_wr_ptr] <= 1'b0;
        end
        if (i_push_b) begin
            mem[w_wr_ptr_b]   <= i_data_b;
            src_b[w_wr_ptr_b] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_cnt_a  <= '0;
            r_cnt_b  <= '0;
        end else begin
            r_wr_ptr <= r_wr_ptr + PTR_W'(i_push_a) + PTR_W'(i_push_b);
            r_rd_ptr <= r_rd_ptr + PTR_W'(i_pop);
            r_cnt_a  <= r_cnt_a + CNT_W'(i_push_a) - CNT_W'(w_pop_a);
            r_cnt_b  <= r_cnt_b + CNT_W'(i_push_b) - CNT_W'(w_pop_b);
        end
    end

endmodule

`default_nettype wire

// File: design/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    // master side of the write channels
    typedef struct packed {
        logic [3:0]  awid;
        logic [31:0] awaddr;
        logic [7:0]  awlen;
        logic [2:0]  awsize;
        logic [1:0]  awburst;
        logic [1:0]  awlock;
        logic [3:0]  awcache;
        logic [2:0]  awprot;
        logic        awvalid;
        logic [3:0]  wid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wlast;
        logic        wvalid;
        logic        bready;
    } axi_w_req;

    // slave side of the write channels
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axi_w_resp;

endpackage

`default_nettype wire

// File: design/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

    // data and address word of the memory stage
    typedef logic [31:0] word;

    // one write request as it sits in the ordered queue
    typedef struct packed {
        word        addr; // byte address
        logic [7:0] len;  // beats minus one
        logic [2:0] size; // axi size code
        logic [3:0] wen;  // byte strobe
    } mem_write_req;

endpackage

`default_nettype wire
